// File: src/exec_pkg.sv
/* integer execution cluster types
   data word, flags, opcodes and result-bus forward selects */
package exec_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  typedef logic [63:0] word_t;    // operands, results, buses
  typedef logic [3:0]  flags_t;   // {overflow, sign, zero, carry}
  typedef logic [7:0]  op_t;
  typedef logic [3:0]  fwd_sel_t; // result-bus index

  // flag bit positions
  localparam int FL_CARRY = 0;
  localparam int FL_ZERO  = 1;
  localparam int FL_SIGN  = 2;
  localparam int FL_OVF   = 3;

  ////////////////////////////////////////////////////////////
  // forwarding
  ////////////////////////////////////////////////////////////

  localparam fwd_sel_t FWD_NONE = 4'hf; // take the register-file value

  // alu and shifter results sit above the external buses
  localparam int N_OWN_BUS = 2;

  ////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////

  // alu lane
  localparam op_t OP_ADD64 = 8'h01;
  localparam op_t OP_SUB64 = 8'h02;
  localparam op_t OP_ADD32 = 8'h03;
  localparam op_t OP_SUB32 = 8'h04;
  localparam op_t OP_AND64 = 8'h05;
  localparam op_t OP_OR64  = 8'h06;
  localparam op_t OP_XOR64 = 8'h07;

  // shift lane
  localparam op_t OP_SHL64 = 8'h10;
  localparam op_t OP_SHR64 = 8'h11;
  localparam op_t OP_SAR64 = 8'h12;
  localparam op_t OP_SHL32 = 8'h13;
  localparam op_t OP_SHR32 = 8'h14;
  localparam op_t OP_SAR32 = 8'h15;

endpackage

// File: src/operand_bypass.sv
/* operand bypass
   picks rf value, current bus or previous-cycle bus and registers it */
`timescale 1ns/1ns

module operand_bypass #(
  parameter int N_BUS = 6
) (
  input  logic                         clk,
  input  logic                         reset,
  input  exec_pkg::word_t              rf_val,
  input  exec_pkg::fwd_sel_t           fwd,
  input  exec_pkg::fwd_sel_t           fwd_prev,
  input  exec_pkg::word_t [N_BUS-1:0]  bus,
  output exec_pkg::word_t              opnd
);
  import exec_pkg::*;

  word_t [N_BUS-1:0] bus_prev; // bus values one cycle back
  word_t             opnd_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      bus_prev <= '0;
    end else begin
      bus_prev <= bus;
    end
  end

  // current-cycle forward wins over the older copy
  always_comb begin
    opnd_d = rf_val;
    for (int i = 0; i < N_BUS; i++) begin
      if (fwd_prev == fwd_sel_t'(i)) begin
        opnd_d = bus_prev[i];
      end
    end
    for (int i = 0; i < N_BUS; i++) begin
      if (fwd == fwd_sel_t'(i)) begin
        opnd_d = bus[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    opnd <= opnd_d; // lane reads it in the execute cycle
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // an index that is not FWD_NONE must name a real bus
  a_fwd_range: assert property (@(posedge clk) disable iff (reset)
    (fwd == FWD_NONE || fwd < N_BUS) && (fwd_prev == FWD_NONE || fwd_prev < N_BUS));

  // scheduler sends one source per operand
  a_fwd_excl: assert property (@(posedge clk) disable iff (reset)
    !(fwd != FWD_NONE && fwd_prev != FWD_NONE));

endmodule

// File: src/int_alu.sv
/* integer alu lane
   add, sub and logic at 64/32 bits with flags, registered result */
`timescale 1ns/1ns

module int_alu (
  input  logic               clk,
  input  logic               reset,
  input  logic               en,
  input  exec_pkg::op_t      op,
  input  exec_pkg::word_t    a,
  input  exec_pkg::word_t    b,
  output exec_pkg::word_t    res,
  output exec_pkg::flags_t   flags,
  output logic               rten
);
  import exec_pkg::*;

  logic        en_q;
  op_t         op_q;
  logic        is32;
  logic        is_sub;
  logic        is_logic;
  word_t       b_eff;
  logic [64:0] sum64;
  logic [32:0] sum32;
  word_t       res_d;
  flags_t      flags_d;
  logic        a_msb, b_msb, r_msb;

  ////////////////////////////////////////////////////////////
  // execute, from the registered opcode
  ////////////////////////////////////////////////////////////

  always_comb begin
    is32     = (op_q == OP_ADD32) || (op_q == OP_SUB32);
    is_sub   = (op_q == OP_SUB64) || (op_q == OP_SUB32);
    is_logic = (op_q == OP_AND64) || (op_q == OP_OR64) || (op_q == OP_XOR64);

    b_eff = is_sub ? ~b : b; // a + ~b + 1
    sum64 = {1'b0, a} + {1'b0, b_eff} + {64'b0, is_sub};
    sum32 = {1'b0, a[31:0]} + {1'b0, b_eff[31:0]} + {32'b0, is_sub};

    case (op_q)
      OP_AND64: res_d = a & b;
      OP_OR64:  res_d = a | b;
      OP_XOR64: res_d = a ^ b;
      default:  res_d = is32 ? {32'b0, sum32[31:0]} : sum64[63:0];
    endcase

    a_msb = is32 ? a[31] : a[63];
    b_msb = is32 ? b_eff[31] : b_eff[63];
    r_msb = is32 ? res_d[31] : res_d[63];

    flags_d = '0;
    flags_d[FL_SIGN] = r_msb;
    flags_d[FL_ZERO] = (res_d == '0); // upper half already zero at 32 bits
    if (!is_logic) begin
      flags_d[FL_CARRY] = is32 ? sum32[32] : sum64[64];
      flags_d[FL_OVF]   = (a_msb == b_msb) && (r_msb != a_msb);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en_q  <= 1'b0;
      op_q  <= '0;
      rten  <= 1'b0;
      res   <= '0;
      flags <= '0;
    end else begin
      en_q  <= en;
      op_q  <= op;
      rten  <= en_q;
      res   <= en_q ? res_d : '0;  // bus idles at zero
      flags <= en_q ? flags_d : '0;
    end
  end

  // the scheduler only routes alu opcodes here
  a_alu_op: assert property (@(posedge clk) disable iff (reset)
    en |-> (op >= OP_ADD64 && op <= OP_XOR64));

endmodule

// File: src/int_shifter.sv
/* integer shift lane
   shl, shr and sar at 64/32 bits with flags, registered result */
`timescale 1ns/1ns

module int_shifter (
  input  logic               clk,
  input  logic               reset,
  input  logic               en,
  input  exec_pkg::op_t      op,
  input  exec_pkg::word_t    a,
  input  exec_pkg::word_t    b,
  output exec_pkg::word_t    res,
  output exec_pkg::flags_t   flags,
  output logic               rten
);
  import exec_pkg::*;

  logic        en_q;
  op_t         op_q;
  logic        dir_right;
  logic        arith;
  logic        is32;
  logic [5:0]  sh_amt;
  logic [31:0] r32;
  word_t       res_d;
  flags_t      flags_d;

  always_comb begin
    dir_right = (op_q != OP_SHL64) && (op_q != OP_SHL32);
    arith     = (op_q == OP_SAR64) || (op_q == OP_SAR32);
    is32      = (op_q == OP_SHL32) || (op_q == OP_SHR32) || (op_q == OP_SAR32);
    sh_amt    = is32 ? {1'b0, b[4:0]} : b[5:0];

    if (!dir_right)  r32 = a[31:0] << sh_amt;
    else if (arith)  r32 = $signed(a[31:0]) >>> sh_amt; // fill from bit 31
    else             r32 = a[31:0] >> sh_amt;

    if (is32)           res_d = {32'b0, r32};
    else if (!dir_right) res_d = a << sh_amt;
    else if (arith)      res_d = $signed(a) >>> sh_amt;
    else                 res_d = a >> sh_amt;

    flags_d = '0; // carry and overflow stay clear
    flags_d[FL_ZERO] = (res_d == '0);
    flags_d[FL_SIGN] = is32 ? res_d[31] : res_d[63];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en_q  <= 1'b0;
      op_q  <= '0;
      rten  <= 1'b0;
      res   <= '0;
      flags <= '0;
    end else begin
      en_q  <= en;
      op_q  <= op;
      rten  <= en_q;
      res   <= en_q ? res_d : '0;
      flags <= en_q ? flags_d : '0;
    end
  end

  a_shf_op: assert property (@(posedge clk) disable iff (reset)
    en |-> (op >= OP_SHL64 && op <= OP_SAR32));

endmodule

// File: src/int_exec_cluster.sv
/* integer execution cluster
   alu and shift lanes behind per-operand bypass stages */
`timescale 1ns/1ns

module int_exec_cluster #(
  parameter int N_EXT_BUS = 4
) (
  input  logic                            clk,
  input  logic                            reset,
  input  exec_pkg::word_t [N_EXT_BUS-1:0] ext_bus,
  input  logic                            alu_en,
  input  exec_pkg::op_t                   alu_op,
  input  exec_pkg::word_t                 alu_a, alu_b,
  input  exec_pkg::fwd_sel_t              alu_a_fwd, alu_a_fwd_prev,
  input  exec_pkg::fwd_sel_t              alu_b_fwd, alu_b_fwd_prev,
  input  logic                            shf_en,
  input  exec_pkg::op_t                   shf_op,
  input  exec_pkg::word_t                 shf_a, shf_b,
  input  exec_pkg::fwd_sel_t              shf_a_fwd, shf_a_fwd_prev,
  input  exec_pkg::fwd_sel_t              shf_b_fwd, shf_b_fwd_prev,
  output exec_pkg::word_t                 alu_res,
  output exec_pkg::flags_t                alu_flags,
  output logic                            alu_rten,
  output exec_pkg::word_t                 shf_res,
  output exec_pkg::flags_t                shf_flags,
  output logic                            shf_rten
);
  import exec_pkg::*;

  localparam int N_BUS = N_EXT_BUS + N_OWN_BUS;

  word_t [N_BUS-1:0] res_bus;
  word_t             alu_opa, alu_opb, shf_opa, shf_opb;

  // external buses low, then alu at N_EXT_BUS and shifter above it
  assign res_bus = {shf_res, alu_res, ext_bus};

  operand_bypass #(.N_BUS(N_BUS)) u_alu_a (.clk(clk), .reset(reset), .rf_val(alu_a),
    .fwd(alu_a_fwd), .fwd_prev(alu_a_fwd_prev), .bus(res_bus), .opnd(alu_opa));
  operand_bypass #(.N_BUS(N_BUS)) u_alu_b (.clk(clk), .reset(reset), .rf_val(alu_b),
    .fwd(alu_b_fwd), .fwd_prev(alu_b_fwd_prev), .bus(res_bus), .opnd(alu_opb));
  operand_bypass #(.N_BUS(N_BUS)) u_shf_a (.clk(clk), .reset(reset), .rf_val(shf_a),
    .fwd(shf_a_fwd), .fwd_prev(shf_a_fwd_prev), .bus(res_bus), .opnd(shf_opa));
  operand_bypass #(.N_BUS(N_BUS)) u_shf_b (.clk(clk), .reset(reset), .rf_val(shf_b),
    .fwd(shf_b_fwd), .fwd_prev(shf_b_fwd_prev), .bus(res_bus), .opnd(shf_opb));

  int_alu u_alu (.clk(clk), .reset(reset), .en(alu_en), .op(alu_op),
    .a(alu_opa), .b(alu_opb), .res(alu_res), .flags(alu_flags), .rten(alu_rten));

  int_shifter u_shf (.clk(clk), .reset(reset), .en(shf_en), .op(shf_op),
    .a(shf_opa), .b(shf_opb), .res(shf_res), .flags(shf_flags), .rten(shf_rten));

endmodule

// File: tb/exec_checker.sv
/* result checker for the integer execution cluster
   compares each lane's result pulse against queued expected values */
`timescale 1ns/1ns

module exec_checker (
  input  logic             clk,
  input  exec_pkg::word_t  alu_res,
  input  exec_pkg::flags_t alu_flags,
  input  logic             alu_rten,
  input  exec_pkg::word_t  shf_res,
  input  exec_pkg::flags_t shf_flags,
  input  logic             shf_rten
);
  import exec_pkg::*;

  localparam int LATENCY = 2; // cycles from issue to result

  int     cyc          = 0;
  int     mismatch_cnt = 0;
  int     other_cnt    = 0;
  int     alu_name_q[$];
  int     alu_cyc_q[$];
  word_t  alu_res_q[$];
  flags_t alu_flg_q[$];
  int     shf_name_q[$];
  int     shf_cyc_q[$];
  word_t  shf_res_q[$];
  flags_t shf_flg_q[$];

  always @(posedge clk) begin
    cyc <= cyc + 1; // read at the falling edge, so it is stable there
  end

  task automatic push_alu(input int name, input word_t res, input flags_t flg);
    alu_name_q.push_back(name);
    alu_cyc_q.push_back(cyc);
    alu_res_q.push_back(res);
    alu_flg_q.push_back(flg);
  endtask

  task automatic push_shf(input int name, input word_t res, input flags_t flg);
    shf_name_q.push_back(name);
    shf_cyc_q.push_back(cyc);
    shf_res_q.push_back(res);
    shf_flg_q.push_back(flg);
  endtask

  function automatic int pending();
    return alu_res_q.size() + shf_res_q.size();
  endfunction

  ////////////////////////////////////////////////////////////
  // comparing
  ////////////////////////////////////////////////////////////

  task automatic compare_result(input string lane, input int name, input int issue_cyc,
                                input word_t exp_res, input flags_t exp_flg,
                                input word_t act_res, input flags_t act_flg);
    if (cyc != issue_cyc + LATENCY) begin
      other_cnt++;
      $display("%s line %0d: result came %0d cycles after issue instead of %0d",
               lane, name, cyc - issue_cyc, LATENCY);
    end
    if (act_res !== exp_res || act_flg !== exp_flg) begin
      mismatch_cnt++;
      $display("Mismatch %s line %0d: expected res %h flags %h, actual res %h flags %h",
               lane, name, exp_res, exp_flg, act_res, act_flg);
    end
  endtask

  // no pulse means the lane must sit at zero
  task automatic check_idle(input string lane, input word_t act_res, input flags_t act_flg);
    if (act_res !== '0 || act_flg !== '0) begin
      mismatch_cnt++;
      $display("Mismatch %s idle: expected res 0 flags 0, actual res %h flags %h",
               lane, act_res, act_flg);
    end
  endtask

  always @(negedge clk) begin
    if (cyc > 0) begin
      if (alu_rten === 1'b1) begin
        if (alu_res_q.size() == 0) begin
          other_cnt++;
          $display("alu lane: result pulse with no operation outstanding");
        end else begin
          compare_result("alu", alu_name_q.pop_front(), alu_cyc_q.pop_front(),
                         alu_res_q.pop_front(), alu_flg_q.pop_front(), alu_res, alu_flags);
        end
      end else begin
        check_idle("alu", alu_res, alu_flags);
      end
      if (shf_rten === 1'b1) begin
        if (shf_res_q.size() == 0) begin
          other_cnt++;
          $display("shift lane: result pulse with no operation outstanding");
        end else begin
          compare_result("shf", shf_name_q.pop_front(), shf_cyc_q.pop_front(),
                         shf_res_q.pop_front(), shf_flg_q.pop_front(), shf_res, shf_flags);
        end
      end else begin
        check_idle("shf", shf_res, shf_flags);
      end
    end
  end

  task automatic report_leftover();
    if (alu_res_q.size() != 0) begin
      other_cnt += alu_res_q.size();
      $display("alu lane: %0d issued operations never produced a result", alu_res_q.size());
    end
    if (shf_res_q.size() != 0) begin
      other_cnt += shf_res_q.size();
      $display("shift lane: %0d issued operations never produced a result", shf_res_q.size());
    end
  endtask

endmodule

// File: tb/tb_int_exec.sv
/* integer execution cluster testbench
   replays the stimulus file through both lanes, exec_checker compares */
`timescale 1ns/1ns

module tb_int_exec;
  import exec_pkg::*;

  localparam int N_EXT_BUS = 4;
  localparam int N_FIELD   = 24;  // values per stimulus line
  localparam int MAX_LINES = 64;
  localparam int RESET_CYC = 16;

  logic                  clk;
  logic                  reset;
  word_t [N_EXT_BUS-1:0] ext_bus;
  logic                  alu_en;
  op_t                   alu_op;
  word_t                 alu_a;
  word_t                 alu_b;
  fwd_sel_t              alu_a_fwd;
  fwd_sel_t              alu_a_fwd_prev;
  fwd_sel_t              alu_b_fwd;
  fwd_sel_t              alu_b_fwd_prev;
  logic                  shf_en;
  op_t                   shf_op;
  word_t                 shf_a;
  word_t                 shf_b;
  fwd_sel_t              shf_a_fwd;
  fwd_sel_t              shf_a_fwd_prev;
  fwd_sel_t              shf_b_fwd;
  fwd_sel_t              shf_b_fwd_prev;
  word_t                 alu_res;
  flags_t                alu_flags;
  logic                  alu_rten;
  word_t                 shf_res;
  flags_t                shf_flags;
  logic                  shf_rten;

  logic [63:0] stim [0:MAX_LINES*N_FIELD]; // word 0 holds the line count
  int          n_lines;
  int          cycles = 0;
  int          limit  = 1000;

  int_exec_cluster #(.N_EXT_BUS(N_EXT_BUS)) UUT (.clk(clk), .reset(reset), .ext_bus(ext_bus),
    .alu_en(alu_en), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
    .alu_a_fwd(alu_a_fwd), .alu_a_fwd_prev(alu_a_fwd_prev),
    .alu_b_fwd(alu_b_fwd), .alu_b_fwd_prev(alu_b_fwd_prev),
    .shf_en(shf_en), .shf_op(shf_op), .shf_a(shf_a), .shf_b(shf_b),
    .shf_a_fwd(shf_a_fwd), .shf_a_fwd_prev(shf_a_fwd_prev),
    .shf_b_fwd(shf_b_fwd), .shf_b_fwd_prev(shf_b_fwd_prev),
    .alu_res(alu_res), .alu_flags(alu_flags), .alu_rten(alu_rten),
    .shf_res(shf_res), .shf_flags(shf_flags), .shf_rten(shf_rten));

  exec_checker chk (.clk(clk),
    .alu_res(alu_res), .alu_flags(alu_flags), .alu_rten(alu_rten),
    .shf_res(shf_res), .shf_flags(shf_flags), .shf_rten(shf_rten));

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic idle_inputs();
    ext_bus        = '0;
    alu_en         = 1'b0;
    alu_op         = '0;
    alu_a          = '0;
    alu_b          = '0;
    alu_a_fwd      = FWD_NONE;
    alu_a_fwd_prev = FWD_NONE;
    alu_b_fwd      = FWD_NONE;
    alu_b_fwd_prev = FWD_NONE;
    shf_en         = 1'b0;
    shf_op         = '0;
    shf_a          = '0;
    shf_b          = '0;
    shf_a_fwd      = FWD_NONE;
    shf_a_fwd_prev = FWD_NONE;
    shf_b_fwd      = FWD_NONE;
    shf_b_fwd_prev = FWD_NONE;
  endtask

  ////////////////////////////////////////////////////////////
  // one stimulus line per cycle
  ////////////////////////////////////////////////////////////

  task automatic drive_line(input int ln);
    int base;
    base = 1 + ln * N_FIELD;
    for (int i = 0; i < N_EXT_BUS; i++) begin
      ext_bus[i] = stim[base+i];
    end
    alu_en         = stim[base+4][0];
    alu_op         = stim[base+5][7:0];
    alu_a          = stim[base+6];
    alu_b          = stim[base+7];
    alu_a_fwd      = stim[base+8][3:0];
    alu_a_fwd_prev = stim[base+9][3:0];
    alu_b_fwd      = stim[base+10][3:0];
    alu_b_fwd_prev = stim[base+11][3:0];
    if (alu_en) begin
      chk.push_alu(ln, stim[base+12], stim[base+13][3:0]);
    end
    shf_en         = stim[base+14][0];
    shf_op         = stim[base+15][7:0];
    shf_a          = stim[base+16];
    shf_b          = stim[base+17];
    shf_a_fwd      = stim[base+18][3:0];
    shf_a_fwd_prev = stim[base+19][3:0];
    shf_b_fwd      = stim[base+20][3:0];
    shf_b_fwd_prev = stim[base+21][3:0];
    if (shf_en) begin
      chk.push_shf(ln, stim[base+22], stim[base+23][3:0]);
    end
  endtask

  initial begin
    idle_inputs();
    reset = 1'b1;
    $readmemh("tb/exec_input.txt", stim);
    n_lines = int'(stim[0]);
    limit   = n_lines + RESET_CYC + 20;
    repeat (RESET_CYC) @(negedge clk);
    reset = 1'b0;
    for (int ln = 0; ln < n_lines; ln++) begin
      drive_line(ln);
      @(negedge clk);
    end
    idle_inputs();
    while (chk.pending() != 0) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk); // stray pulses would show here
    chk.report_leftover();
    $display("closing report: %0d mismatches, %0d other errors",
             chk.mismatch_cnt, chk.other_cnt);
    if (chk.mismatch_cnt + chk.other_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: tb/exec_input.txt
// first value: line count. per line: ext0-3, then alu and shifter, each as
// en op a b a_fwd a_fwd_prev b_fwd b_fwd_prev exp_res exp_flags
1f
0 0 0 0  0 0 0 0 f f f f 0 0  0 0 0 0 f f f f 0 0
0 0 0 0  0 0 0 0 f f f f 0 0  0 0 0 0 f f f f 0 0
0 0 0 0  1 1 1 2 f f f f 3 0  1 10 1 0 f f f f 1 0
0 0 0 0  1 1 ffffffffffffffff 1 f f f f 0 3  1 10 1 3f f f f f 8000000000000000 4
0 0 0 0  1 1 7fffffffffffffff 1 f f f f 8000000000000000 c  1 11 8000000000000000 3f f f f f 1 0
0 0 0 0  1 2 5 5 f f f f 0 3  1 11 ff 8 f f f f 0 2
0 0 0 0  1 2 3 5 f f f f fffffffffffffffe 4  1 12 8000000000000000 3f f f f f ffffffffffffffff 4
0 0 0 0  1 2 8000000000000000 1 f f f f 7fffffffffffffff 9  1 12 4000000000000000 44 f f f f 0400000000000000 0
0 0 0 0  1 3 aaaaaaaaffffffff 1 f f f f 0 3  1 13 ffffffff00000001 1f f f f f 80000000 4
0 0 0 0  1 3 7fffffff 1 f f f f 80000000 c  1 13 5 20 f f f f 5 0
0 0 0 0  1 4 1 2 f f f f ffffffff 4  1 14 ffffffff80000000 1f f f f f 1 0
0 0 0 0  1 4 80000000 1 f f f f 7fffffff 9  1 15 80000000 1f f f f f ffffffff 4
0 0 0 0  1 5 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f f f f f 0f000f000f000f00 0  1 15 ffffffff40000000 4 f f f f 4000000 0
0 0 0 0  1 6 8000000000000000 1 f f f f 8000000000000001 4  1 15 f0000000 0 f f f f f0000000 4
0 0 0 0  1 7 1234 1234 f f f f 0 2  1 14 1 1 f f f f 0 2
100 200 300 404  1 1 0 5 0 f f f 105 0  1 10 0 4 2 f f f 3000 0
11 22 33 44  1 1 0 0 f 1 3 f 244 0  1 11 ff00 0 f f f 3 ff0 0
0 0 0 0  1 2 0 0 f 0 f 1 ffffffffffffffef 4  1 12 0 1 f 2 f f 19 0
0 8 0 0  1 5 0 c 1 f f f 8 0  1 10 1 0 f f 1 f 100 0
0 0 0 0  1 1 10 20 f f f f 30 0  1 10 3 4 f f f f 30 0
0 0 0 0  1 2 100 1 f f f f ff 1  0 0 0 0 f f f f 0 0
0 0 0 0  1 1 0 5 4 f f f 35 0  1 10 0 1 4 f f f 60 0
0 0 0 0  1 1 0 0 4 f f 4 12f 0  1 11 0 4 f 5 f f 3 0
0 0 0 0  1 1 0 0 5 f f 4 15f 0  1 10 0 4 f 4 f f ff0 0
0 0 0 0  1 2 0 0 4 f 4 f 0 3  0 0 0 0 f f f f 0 0
0 0 0 0  1 1 0 0 f 5 4 f 162 0  0 0 0 0 f f f f 0 0
0 0 0 0  1 3 0 ffffffff 4 f f f ffffffff 4  0 0 0 0 f f f f 0 0
0 0 0 0  1 6 0 0 f f f f 0 2  1 13 ffffffff 1 f f f f fffffffe 4
0 0 0 0  0 0 0 0 f f f f 0 0  0 0 0 0 f f f f 0 0
0 0 0 0  0 0 0 0 f f f f 0 0  0 0 0 0 f f f f 0 0
0 0 0 0  0 0 0 0 f f f f 0 0  0 0 0 0 f f f f 0 0

// File: sources.f
src/exec_pkg.sv
src/operand_bypass.sv
src/int_alu.sv
src/int_shifter.sv
src/int_exec_cluster.sv
tb/exec_checker.sv
tb/tb_int_exec.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the integer execution cluster testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_int_exec -o sim_int_exec
out=$(./obj_dir/sim_int_exec)
echo "$out"
if echo "$out" | grep -q "NO ERRORS"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
